//--- verilog/core_region_params.svh
`ifndef CORE_REGION_PARAMS_SVH
`define CORE_REGION_PARAMS_SVH

// word index width of the unified RAM
`define RAM_ADDR_WIDTH 10

// address bits 31:24 that select the local RAM
`define LOCAL_TAG 8'h00

`endif

//--- verilog/mem_types_pkg.sv
`default_nettype none

`include "core_region_params.svh"

package mem_types_pkg;

  typedef logic [31:0] word_t;

  // one bit per byte lane
  typedef logic [3:0] be_t;

  typedef logic [31:0] addr_t;

  typedef logic [`RAM_ADDR_WIDTH-1:0] ram_idx_t;

endpackage

`default_nettype wire

//--- verilog/lsu_route_pkg.sv
`default_nettype none

package lsu_route_pkg;

  // where the next LSU response comes from
  typedef enum logic
  {
    SRC_RAM = 1'b0,
    SRC_EXT = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

//--- verilog/lsu_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_params.svh"

module lsu_demux
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  input  wire logic                 lsu_req_i,
  input  wire mem_types_pkg::addr_t lsu_addr_i,
  input  wire logic                 lsu_we_i,
  input  wire mem_types_pkg::be_t   lsu_be_i,
  input  wire mem_types_pkg::word_t lsu_wdata_i,
  output logic                      lsu_gnt_o,
  output logic                      lsu_rvalid_o,
  output mem_types_pkg::word_t      lsu_rdata_o,

  output mem_types_pkg::addr_t      req_addr_o,
  output logic                      req_we_o,
  output mem_types_pkg::be_t        req_be_o,
  output mem_types_pkg::word_t      req_wdata_o,

  output logic                      loc_req_o,
  input  wire logic                 loc_gnt_i,
  input  wire logic                 loc_rvalid_i,
  input  wire mem_types_pkg::word_t loc_rdata_i,

  output logic                      ext_req_o,
  input  wire logic                 ext_gnt_i,
  input  wire logic                 ext_rvalid_i,
  input  wire mem_types_pkg::word_t ext_rdata_i
);

  logic                     is_local;
  lsu_route_pkg::resp_src_e src_q;

  assign is_local = (lsu_addr_i[31:24] == `LOCAL_TAG);

  assign loc_req_o = lsu_req_i &  is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // shared request fields, fanned out to both targets
  assign req_addr_o  = lsu_addr_i;
  assign req_we_o    = lsu_we_i;
  assign req_be_o    = lsu_be_i;
  assign req_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = is_local ? (loc_req_o & loc_gnt_i) : (ext_req_o & ext_gnt_i);

  // remember the target of the accepted request
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      src_q <= lsu_route_pkg::SRC_RAM;
    end
    else if (lsu_gnt_o)
    begin
      src_q <= is_local ? lsu_route_pkg::SRC_RAM : lsu_route_pkg::SRC_EXT;
    end
  end

  always_comb
  begin
    case (src_q)
      lsu_route_pkg::SRC_EXT:
      begin
        lsu_rvalid_o = ext_rvalid_i;
        lsu_rdata_o  = ext_rdata_i;
      end
      default:
      begin
        lsu_rvalid_o = loc_rvalid_i;
        lsu_rdata_o  = loc_rdata_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  input  wire logic                    p0_req_i,
  input  wire mem_types_pkg::ram_idx_t p0_addr_i,
  input  wire logic                    p0_we_i,
  input  wire mem_types_pkg::be_t      p0_be_i,
  input  wire mem_types_pkg::word_t    p0_wdata_i,
  output logic                         p0_gnt_o,
  output logic                         p0_rvalid_o,
  output mem_types_pkg::word_t         p0_rdata_o,

  input  wire logic                    p1_req_i,
  input  wire mem_types_pkg::ram_idx_t p1_addr_i,
  input  wire logic                    p1_we_i,
  input  wire mem_types_pkg::be_t      p1_be_i,
  input  wire mem_types_pkg::word_t    p1_wdata_i,
  output logic                         p1_gnt_o,
  output logic                         p1_rvalid_o,
  output mem_types_pkg::word_t         p1_rdata_o,

  output logic                         ram_en_o,
  output mem_types_pkg::ram_idx_t      ram_addr_o,
  output logic                         ram_we_o,
  output mem_types_pkg::be_t           ram_be_o,
  output mem_types_pkg::word_t         ram_wdata_o,
  input  wire mem_types_pkg::word_t    ram_rdata_i
);

  logic [1:0] granted_q;

  // port 0 always wins
  assign p0_gnt_o = p0_req_i;
  assign p1_gnt_o = p1_req_i & ~p0_req_i;

  assign ram_en_o    = p0_req_i | p1_req_i;
  assign ram_addr_o  = p0_req_i ? p0_addr_i  : p1_addr_i;
  assign ram_we_o    = p0_req_i ? p0_we_i    : p1_we_i;
  assign ram_be_o    = p0_req_i ? p0_be_i    : p1_be_i;
  assign ram_wdata_o = p0_req_i ? p0_wdata_i : p1_wdata_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      granted_q <= 2'b00;
    end
    else
    begin
      granted_q <= {p1_gnt_o, p0_gnt_o};
    end
  end

  // response one cycle after the grant
  assign p0_rvalid_o = granted_q[0];
  assign p1_rvalid_o = granted_q[1];

  assign p0_rdata_o = granted_q[0] ? ram_rdata_i : '0;
  assign p1_rdata_o = granted_q[1] ? ram_rdata_i : '0;

endmodule

`default_nettype wire

//--- verilog/unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_params.svh"

module unified_mem
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,

  // fetch port, read only
  input  wire logic                    a_req_i,
  input  wire mem_types_pkg::ram_idx_t a_addr_i,
  output logic                         a_gnt_o,
  output logic                         a_rvalid_o,
  output mem_types_pkg::word_t         a_rdata_o,

  input  wire logic                    b_en_i,
  input  wire mem_types_pkg::ram_idx_t b_addr_i,
  input  wire logic                    b_we_i,
  input  wire mem_types_pkg::be_t      b_be_i,
  input  wire mem_types_pkg::word_t    b_wdata_i,
  output mem_types_pkg::word_t         b_rdata_o
);

  mem_types_pkg::word_t mem [0:(1 << `RAM_ADDR_WIDTH)-1];

  assign a_gnt_o = a_req_i;

  always_ff @(posedge clk)
  begin
    if (a_req_i)
    begin
      a_rdata_o <= mem[a_addr_i];
    end
  end

  // read-first on port B
  always_ff @(posedge clk)
  begin
    if (b_en_i)
    begin
      b_rdata_o <= mem[b_addr_i];
      for (int i = 0; i < 4; i++)
      begin
        if (b_we_i && b_be_i[i])
        begin
          mem[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      a_rvalid_o <= 1'b0;
    end
    else
    begin
      a_rvalid_o <= a_req_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_region.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_region_params.svh"

module core_region
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  input  wire logic                 lsu_req_i,
  input  wire mem_types_pkg::addr_t lsu_addr_i,
  input  wire logic                 lsu_we_i,
  input  wire mem_types_pkg::be_t   lsu_be_i,
  input  wire mem_types_pkg::word_t lsu_wdata_i,
  output logic                      lsu_gnt_o,
  output logic                      lsu_rvalid_o,
  output mem_types_pkg::word_t      lsu_rdata_o,

  input  wire logic                 instr_req_i,
  input  wire mem_types_pkg::addr_t instr_addr_i,
  output logic                      instr_gnt_o,
  output logic                      instr_rvalid_o,
  output mem_types_pkg::word_t      instr_rdata_o,

  output logic                      ext_m_req_o,
  output mem_types_pkg::addr_t      ext_m_addr_o,
  output logic                      ext_m_we_o,
  output mem_types_pkg::be_t        ext_m_be_o,
  output mem_types_pkg::word_t      ext_m_wdata_o,
  input  wire logic                 ext_m_gnt_i,
  input  wire logic                 ext_m_rvalid_i,
  input  wire mem_types_pkg::word_t ext_m_rdata_i,

  input  wire logic                 ext_s_req_i,
  input  wire mem_types_pkg::addr_t ext_s_addr_i,
  input  wire logic                 ext_s_we_i,
  input  wire mem_types_pkg::be_t   ext_s_be_i,
  input  wire mem_types_pkg::word_t ext_s_wdata_i,
  output logic                      ext_s_gnt_o,
  output logic                      ext_s_rvalid_o,
  output mem_types_pkg::word_t      ext_s_rdata_o
);

  // lsu request fields after the demux
  mem_types_pkg::addr_t     req_addr;
  logic                     req_we;
  mem_types_pkg::be_t       req_be;
  mem_types_pkg::word_t     req_wdata;

  logic                     loc_req;
  logic                     loc_gnt;
  logic                     loc_rvalid;
  mem_types_pkg::word_t     loc_rdata;

  logic                     ram_en;
  mem_types_pkg::ram_idx_t  ram_addr;
  logic                     ram_we;
  mem_types_pkg::be_t       ram_be;
  mem_types_pkg::word_t     ram_wdata;
  mem_types_pkg::word_t     ram_rdata;

  assign ext_m_addr_o  = req_addr;
  assign ext_m_we_o    = req_we;
  assign ext_m_be_o    = req_be;
  assign ext_m_wdata_o = req_wdata;

  lsu_demux u_lsu_demux
  (
    .clk          ( clk            ),
    .rst_n        ( rst_n          ),
    .lsu_req_i    ( lsu_req_i      ),
    .lsu_addr_i   ( lsu_addr_i     ),
    .lsu_we_i     ( lsu_we_i       ),
    .lsu_be_i     ( lsu_be_i       ),
    .lsu_wdata_i  ( lsu_wdata_i    ),
    .lsu_gnt_o    ( lsu_gnt_o      ),
    .lsu_rvalid_o ( lsu_rvalid_o   ),
    .lsu_rdata_o  ( lsu_rdata_o    ),
    .req_addr_o   ( req_addr       ),
    .req_we_o     ( req_we         ),
    .req_be_o     ( req_be         ),
    .req_wdata_o  ( req_wdata      ),
    .loc_req_o    ( loc_req        ),
    .loc_gnt_i    ( loc_gnt        ),
    .loc_rvalid_i ( loc_rvalid     ),
    .loc_rdata_i  ( loc_rdata      ),
    .ext_req_o    ( ext_m_req_o    ),
    .ext_gnt_i    ( ext_m_gnt_i    ),
    .ext_rvalid_i ( ext_m_rvalid_i ),
    .ext_rdata_i  ( ext_m_rdata_i  )
  );

  // external slave on port 0, local lsu on port 1
  ram_arbiter u_ram_arbiter
  (
    .clk         ( clk                                  ),
    .rst_n       ( rst_n                                ),
    .p0_req_i    ( ext_s_req_i                          ),
    .p0_addr_i   ( ext_s_addr_i[`RAM_ADDR_WIDTH+1:2]    ),
    .p0_we_i     ( ext_s_we_i                           ),
    .p0_be_i     ( ext_s_be_i                           ),
    .p0_wdata_i  ( ext_s_wdata_i                        ),
    .p0_gnt_o    ( ext_s_gnt_o                          ),
    .p0_rvalid_o ( ext_s_rvalid_o                       ),
    .p0_rdata_o  ( ext_s_rdata_o                        ),
    .p1_req_i    ( loc_req                              ),
    .p1_addr_i   ( req_addr[`RAM_ADDR_WIDTH+1:2]        ),
    .p1_we_i     ( req_we                               ),
    .p1_be_i     ( req_be                               ),
    .p1_wdata_i  ( req_wdata                            ),
    .p1_gnt_o    ( loc_gnt                              ),
    .p1_rvalid_o ( loc_rvalid                           ),
    .p1_rdata_o  ( loc_rdata                            ),
    .ram_en_o    ( ram_en                               ),
    .ram_addr_o  ( ram_addr                             ),
    .ram_we_o    ( ram_we                               ),
    .ram_be_o    ( ram_be                               ),
    .ram_wdata_o ( ram_wdata                            ),
    .ram_rdata_i ( ram_rdata                            )
  );

  unified_mem u_unified_mem
  (
    .clk        ( clk                                  ),
    .rst_n      ( rst_n                                ),
    .a_req_i    ( instr_req_i                          ),
    .a_addr_i   ( instr_addr_i[`RAM_ADDR_WIDTH+1:2]    ),
    .a_gnt_o    ( instr_gnt_o                          ),
    .a_rvalid_o ( instr_rvalid_o                       ),
    .a_rdata_o  ( instr_rdata_o                        ),
    .b_en_i     ( ram_en                               ),
    .b_addr_i   ( ram_addr                             ),
    .b_we_i     ( ram_we                               ),
    .b_be_i     ( ram_be                               ),
    .b_wdata_i  ( ram_wdata                            ),
    .b_rdata_o  ( ram_rdata                            )
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int half_period = 10;

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    // release away from the rising edge
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #(half_period) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- testbench/core_region_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_region_tb;

  typedef enum logic [2:0] {P_LSU, P_EXT_M, P_EXT_S, P_FETCH, P_CONT} port_e;

  typedef struct packed {
    port_e                port;
    logic                 we;
    mem_types_pkg::addr_t addr;
    mem_types_pkg::word_t wdata;
    mem_types_pkg::be_t   be;
    mem_types_pkg::word_t exp;
  } entry_t;

  localparam int wait_limit = 50;

  // port, we, address, wdata, be, expected read data
  // P_CONT has the slave write addr and the lsu write addr+4 with inverted data
  localparam entry_t stim_table [0:15] = '{
    '{P_LSU,   1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf,    32'h0},
    '{P_LSU,   1'b1, 32'h0000_0104, 32'ha5a5_a5a5, 4'hf,    32'h0},
    '{P_LSU,   1'b1, 32'h0000_0100, 32'haabb_ccdd, 4'b0101, 32'h0},
    '{P_LSU,   1'b1, 32'h0000_0104, 32'h0000_7e00, 4'b0010, 32'h0},
    '{P_LSU,   1'b0, 32'h0000_0100, 32'h0,         4'hf,    32'h11bb_33dd},
    '{P_LSU,   1'b0, 32'h0000_0104, 32'h0,         4'hf,    32'ha5a5_7ea5},
    '{P_FETCH, 1'b0, 32'h0000_0100, 32'h0,         4'hf,    32'h11bb_33dd},
    '{P_FETCH, 1'b0, 32'h0000_0104, 32'h0,         4'hf,    32'ha5a5_7ea5},
    '{P_EXT_M, 1'b1, 32'h1000_0010, 32'hcafe_f00d, 4'b1100, 32'h0},
    '{P_EXT_M, 1'b0, 32'h1000_0010, 32'h0,         4'hf,    32'h0},
    '{P_EXT_M, 1'b0, 32'h8000_0020, 32'h0,         4'hf,    32'h0},
    '{P_CONT,  1'b1, 32'h0000_0200, 32'h1234_5678, 4'hf,    32'h0},
    '{P_EXT_S, 1'b1, 32'h0000_0300, 32'h0bad_c0de, 4'hf,    32'h0},
    '{P_LSU,   1'b0, 32'h0000_0300, 32'h0,         4'hf,    32'h0bad_c0de},
    '{P_EXT_S, 1'b0, 32'h0000_0100, 32'h0,         4'hf,    32'h11bb_33dd},
    '{P_LSU,   1'b0, 32'h0000_0204, 32'h0,         4'hf,    32'hedcb_a987}
  };

  logic clk;
  logic rst_n;

  logic                 lsu_req_i;
  mem_types_pkg::addr_t lsu_addr_i;
  logic                 lsu_we_i;
  mem_types_pkg::be_t   lsu_be_i;
  mem_types_pkg::word_t lsu_wdata_i;
  logic                 lsu_gnt_o;
  logic                 lsu_rvalid_o;
  mem_types_pkg::word_t lsu_rdata_o;
  logic                 instr_req_i;
  mem_types_pkg::addr_t instr_addr_i;
  logic                 instr_gnt_o;
  logic                 instr_rvalid_o;
  mem_types_pkg::word_t instr_rdata_o;
  logic                 ext_m_req_o;
  mem_types_pkg::addr_t ext_m_addr_o;
  logic                 ext_m_we_o;
  mem_types_pkg::be_t   ext_m_be_o;
  mem_types_pkg::word_t ext_m_wdata_o;
  logic                 ext_m_gnt_i;
  logic                 ext_m_rvalid_i;
  mem_types_pkg::word_t ext_m_rdata_i;
  logic                 ext_s_req_i;
  mem_types_pkg::addr_t ext_s_addr_i;
  logic                 ext_s_we_i;
  mem_types_pkg::be_t   ext_s_be_i;
  mem_types_pkg::word_t ext_s_wdata_i;
  logic                 ext_s_gnt_o;
  logic                 ext_s_rvalid_o;
  mem_types_pkg::word_t ext_s_rdata_o;

  // responder model memory and the last request it accepted
  mem_types_pkg::word_t ext_mem [0:63];
  mem_types_pkg::addr_t cap_addr;
  logic                 cap_we;
  mem_types_pkg::be_t   cap_be;
  mem_types_pkg::word_t cap_wdata;

  // expected local RAM contents keyed by byte address
  mem_types_pkg::word_t ref_mem [mem_types_pkg::addr_t];

  int errors;
  int entries_failed;

  tb_clock_gen u_clock_gen
  (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  core_region u_core_region
  (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .lsu_req_i      ( lsu_req_i      ),
    .lsu_addr_i     ( lsu_addr_i     ),
    .lsu_we_i       ( lsu_we_i       ),
    .lsu_be_i       ( lsu_be_i       ),
    .lsu_wdata_i    ( lsu_wdata_i    ),
    .lsu_gnt_o      ( lsu_gnt_o      ),
    .lsu_rvalid_o   ( lsu_rvalid_o   ),
    .lsu_rdata_o    ( lsu_rdata_o    ),
    .instr_req_i    ( instr_req_i    ),
    .instr_addr_i   ( instr_addr_i   ),
    .instr_gnt_o    ( instr_gnt_o    ),
    .instr_rvalid_o ( instr_rvalid_o ),
    .instr_rdata_o  ( instr_rdata_o  ),
    .ext_m_req_o    ( ext_m_req_o    ),
    .ext_m_addr_o   ( ext_m_addr_o   ),
    .ext_m_we_o     ( ext_m_we_o     ),
    .ext_m_be_o     ( ext_m_be_o     ),
    .ext_m_wdata_o  ( ext_m_wdata_o  ),
    .ext_m_gnt_i    ( ext_m_gnt_i    ),
    .ext_m_rvalid_i ( ext_m_rvalid_i ),
    .ext_m_rdata_i  ( ext_m_rdata_i  ),
    .ext_s_req_i    ( ext_s_req_i    ),
    .ext_s_addr_i   ( ext_s_addr_i   ),
    .ext_s_we_i     ( ext_s_we_i     ),
    .ext_s_be_i     ( ext_s_be_i     ),
    .ext_s_wdata_i  ( ext_s_wdata_i  ),
    .ext_s_gnt_o    ( ext_s_gnt_o    ),
    .ext_s_rvalid_o ( ext_s_rvalid_o ),
    .ext_s_rdata_o  ( ext_s_rdata_o  )
  );

  // old word with the enabled byte lanes replaced
  function automatic mem_types_pkg::word_t merge_word(input mem_types_pkg::word_t old_w,
                                                      input mem_types_pkg::word_t new_w,
                                                      input mem_types_pkg::be_t be);
    mem_types_pkg::word_t w;
    int b;
    w = old_w;
    for (b = 0; b < 4; b++)
    begin
      if (be[b])
        w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic void update_ref(input mem_types_pkg::addr_t addr,
                                     input mem_types_pkg::word_t wdata,
                                     input mem_types_pkg::be_t be);
    mem_types_pkg::word_t old_w;
    old_w = ref_mem.exists(addr) ? ref_mem[addr] : '0;
    ref_mem[addr] = merge_word(old_w, wdata, be);
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got %h, expected %h", sig, got, exp);
    errors++;
  endtask

  task automatic lsu_access(input mem_types_pkg::addr_t addr, input logic we,
                            input mem_types_pkg::be_t be, input mem_types_pkg::word_t wdata,
                            input logic is_local, output mem_types_pkg::word_t rdata);
    int cnt;
    lsu_req_i   <= 1'b1;
    lsu_addr_i  <= addr;
    lsu_we_i    <= we;
    lsu_be_i    <= be;
    lsu_wdata_i <= wdata;
    cnt = 0;
    do
    begin
      @(posedge clk);
      cnt++;
    end
    while (!lsu_gnt_o && cnt < wait_limit);
    lsu_req_i <= 1'b0;
    rdata = '0;
    if (!lsu_gnt_o)
    begin
      $display("lsu_gnt_o did not rise within %0d cycles", wait_limit);
      errors++;
      return;
    end
    // only the addressed target sees the request
    if (is_local && ext_m_req_o !== 1'b0)
      report_mismatch("ext_m_req_o", 32'(ext_m_req_o), 32'h0);
    if (!is_local && ext_m_gnt_i !== 1'b1)
    begin
      $display("lsu_gnt_o rose while ext_m_gnt_i was low");
      errors++;
    end
    cnt = 0;
    do
    begin
      @(posedge clk);
      cnt++;
    end
    while (!lsu_rvalid_o && cnt < wait_limit);
    if (!lsu_rvalid_o)
    begin
      $display("lsu_rvalid_o did not rise within %0d cycles", wait_limit);
      errors++;
    end
    else if (is_local && cnt != 1)
    begin
      $display("lsu_rvalid_o came %0d cycles after lsu_gnt_o instead of 1", cnt);
      errors++;
    end
    rdata = lsu_rdata_o;
  endtask

  task automatic ext_s_access(input mem_types_pkg::addr_t addr, input logic we,
                              input mem_types_pkg::be_t be, input mem_types_pkg::word_t wdata,
                              output mem_types_pkg::word_t rdata);
    int cnt;
    ext_s_req_i   <= 1'b1;
    ext_s_addr_i  <= addr;
    ext_s_we_i    <= we;
    ext_s_be_i    <= be;
    ext_s_wdata_i <= wdata;
    cnt = 0;
    do
    begin
      @(posedge clk);
      cnt++;
    end
    while (!ext_s_gnt_o && cnt < wait_limit);
    ext_s_req_i <= 1'b0;
    if (!ext_s_gnt_o)
    begin
      $display("ext_s_gnt_o did not rise within %0d cycles", wait_limit);
      errors++;
    end
    @(posedge clk);
    if (!ext_s_rvalid_o)
    begin
      $display("ext_s_rvalid_o was low one cycle after ext_s_gnt_o");
      errors++;
    end
    rdata = ext_s_rdata_o;
  endtask

  task automatic fetch_word(input mem_types_pkg::addr_t addr,
                            output mem_types_pkg::word_t rdata);
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    @(posedge clk);
    if (!instr_gnt_o)
    begin
      $display("instr_gnt_o was low while instr_req_i was high");
      errors++;
    end
    instr_req_i <= 1'b0;
    @(posedge clk);
    if (!instr_rvalid_o)
    begin
      $display("instr_rvalid_o did not follow the fetch request by one cycle");
      errors++;
    end
    rdata = instr_rdata_o;
  endtask

  // slave and lsu write in the same cycle and the slave wins
  task automatic contend_writes(input mem_types_pkg::addr_t addr,
                                input mem_types_pkg::word_t wdata);
    int cnt;
    ext_s_req_i   <= 1'b1;
    ext_s_addr_i  <= addr;
    ext_s_we_i    <= 1'b1;
    ext_s_be_i    <= 4'hf;
    ext_s_wdata_i <= wdata;
    lsu_req_i     <= 1'b1;
    lsu_addr_i    <= addr + 32'd4;
    lsu_we_i      <= 1'b1;
    lsu_be_i      <= 4'hf;
    lsu_wdata_i   <= ~wdata;
    @(posedge clk);
    if (!ext_s_gnt_o || lsu_gnt_o)
    begin
      $display("ext slave was not granted ahead of the lsu");
      errors++;
    end
    ext_s_req_i <= 1'b0;
    @(posedge clk);
    if (!ext_s_rvalid_o)
    begin
      $display("ext_s_rvalid_o was low one cycle after ext_s_gnt_o");
      errors++;
    end
    cnt = 0;
    while (!lsu_gnt_o && cnt < wait_limit)
    begin
      @(posedge clk);
      cnt++;
    end
    lsu_req_i <= 1'b0;
    if (!lsu_gnt_o)
    begin
      $display("lsu_gnt_o did not rise within %0d cycles under contention", wait_limit);
      errors++;
      return;
    end
    @(posedge clk);
    if (!lsu_rvalid_o)
    begin
      $display("lsu_rvalid_o was low one cycle after lsu_gnt_o under contention");
      errors++;
    end
    update_ref(addr, wdata, 4'hf);
    update_ref(addr + 32'd4, ~wdata, 4'hf);
  endtask

  task automatic run_entry(input int n);
    entry_t e;
    mem_types_pkg::word_t rdata;
    mem_types_pkg::word_t exp;
    int errors_before;
    e = stim_table[n];
    exp = e.exp;
    errors_before = errors;
    case (e.port)
      P_LSU:
      begin
        lsu_access(e.addr, e.we, e.be, e.wdata, 1'b1, rdata);
        if (!e.we && rdata !== exp) report_mismatch("lsu_rdata_o", rdata, exp);
      end
      P_EXT_M:
      begin
        exp = ext_mem[e.addr[7:2]];
        lsu_access(e.addr, e.we, e.be, e.wdata, 1'b0, rdata);
        if (cap_addr !== e.addr) report_mismatch("ext_m_addr_o", cap_addr, e.addr);
        if (cap_we !== e.we) report_mismatch("ext_m_we_o", 32'(cap_we), 32'(e.we));
        if (cap_be !== e.be) report_mismatch("ext_m_be_o", 32'(cap_be), 32'(e.be));
        if (e.we && cap_wdata !== e.wdata)
          report_mismatch("ext_m_wdata_o", cap_wdata, e.wdata);
        if (!e.we && rdata !== exp) report_mismatch("lsu_rdata_o", rdata, exp);
      end
      P_EXT_S:
      begin
        ext_s_access(e.addr, e.we, e.be, e.wdata, rdata);
        if (!e.we && rdata !== exp) report_mismatch("ext_s_rdata_o", rdata, exp);
      end
      P_FETCH:
      begin
        fetch_word(e.addr, rdata);
        if (rdata !== exp) report_mismatch("instr_rdata_o", rdata, exp);
      end
      default:
      begin
        contend_writes(e.addr, e.wdata);
      end
    endcase
    if (e.we && e.port inside {P_LSU, P_EXT_S}) update_ref(e.addr, e.wdata, e.be);
    if (errors != errors_before) entries_failed++;
    $display("entry %0d %s %s %h: %s", n, e.port.name(), e.we ? "write" : "read", e.addr,
             (errors == errors_before) ? "ok" : "error");
  endtask

  // external master responder with random grant and response delays
  always
  begin : ext_responder
    int delay;
    logic [5:0] idx;
    @(posedge clk);
    if (rst_n && ext_m_req_o)
    begin
      delay = $urandom % 4;
      repeat (delay) @(posedge clk);
      ext_m_gnt_i <= 1'b1;
      @(posedge clk);
      ext_m_gnt_i <= 1'b0;
      cap_addr  = ext_m_addr_o;
      cap_we    = ext_m_we_o;
      cap_be    = ext_m_be_o;
      cap_wdata = ext_m_wdata_o;
      idx = ext_m_addr_o[7:2];
      if (ext_m_we_o) ext_mem[idx] = merge_word(ext_mem[idx], ext_m_wdata_o, ext_m_be_o);
      delay = $urandom % 4;
      repeat (delay) @(posedge clk);
      ext_m_rvalid_i <= 1'b1;
      ext_m_rdata_i  <= ext_mem[idx];
      @(posedge clk);
      ext_m_rvalid_i <= 1'b0;
    end
  end

  initial
  begin
    int cnt;
    int n;
    int sweep_errors;
    mem_types_pkg::word_t rdata;
    void'($urandom(32'h628e));
    lsu_req_i      = 1'b0;
    lsu_addr_i     = '0;
    lsu_we_i       = 1'b0;
    lsu_be_i       = '0;
    lsu_wdata_i    = '0;
    instr_req_i    = 1'b0;
    instr_addr_i   = '0;
    ext_m_gnt_i    = 1'b0;
    ext_m_rvalid_i = 1'b0;
    ext_m_rdata_i  = '0;
    ext_s_req_i    = 1'b0;
    ext_s_addr_i   = '0;
    ext_s_we_i     = 1'b0;
    ext_s_be_i     = '0;
    ext_s_wdata_i  = '0;
    errors         = 0;
    entries_failed = 0;
    for (n = 0; n < 64; n++)
      ext_mem[n] = $urandom;

    cnt = 0;
    while (rst_n !== 1'b1 && cnt < 40)
    begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1)
    begin
      $display("reset was never released");
      errors++;
    end

    // idle outputs after reset
    if (lsu_gnt_o !== 1'b0) report_mismatch("lsu_gnt_o", 32'(lsu_gnt_o), 32'h0);
    if (ext_s_gnt_o !== 1'b0) report_mismatch("ext_s_gnt_o", 32'(ext_s_gnt_o), 32'h0);
    if (lsu_rvalid_o !== 1'b0) report_mismatch("lsu_rvalid_o", 32'(lsu_rvalid_o), 32'h0);
    if (ext_s_rvalid_o !== 1'b0)
      report_mismatch("ext_s_rvalid_o", 32'(ext_s_rvalid_o), 32'h0);
    if (instr_rvalid_o !== 1'b0)
      report_mismatch("instr_rvalid_o", 32'(instr_rvalid_o), 32'h0);
    $display("reset state: %s", (errors == 0) ? "ok" : "error");

    for (n = 0; n < $size(stim_table); n++)
      run_entry(n);

    // read back everything the RAM should hold
    sweep_errors = errors;
    foreach (ref_mem[a])
    begin
      lsu_access(a, 1'b0, 4'hf, '0, 1'b1, rdata);
      if (rdata !== ref_mem[a]) report_mismatch("lsu_rdata_o", rdata, ref_mem[a]);
    end
    $display("ram sweep: %s", (errors == sweep_errors) ? "ok" : "error");

    $display("%0d entries run, %0d failed, %0d errors", $size(stim_table), entries_failed,
             errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/mem_types_pkg.sv
verilog/lsu_route_pkg.sv
verilog/lsu_demux.sv
verilog/ram_arbiter.sv
verilog/unified_mem.sv
verilog/core_region.sv
testbench/tb_clock_gen.sv
testbench/core_region_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_region_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	@rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
